// ==== hdl/fp_sqrt_consts.svh ====
`ifndef FP_SQRT_CONSTS_SVH
`define FP_SQRT_CONSTS_SVH

// Half-precision field widths
`define FP_EXP_W 5
`define FP_MAN_W 10

// Exponent bias of the half-float format
`define FP_BIAS 15

// Significand with two integer bits, shifted up by the mantissa width
`define RAD_W 22

// One result bit per root stage
`define ROOT_W 11

// Unpack, eleven root stages, pack
`define SQRT_LATENCY 13

`endif

// ==== hdl/fp_sqrt_pkg.sv ====
`default_nettype none

`include "fp_sqrt_consts.svh"

package fp_sqrt_pkg;

    // Sign, exponent, mantissa
    typedef logic [`FP_EXP_W+`FP_MAN_W:0] half_t;

    typedef logic [`FP_EXP_W-1:0] exp_t;

    typedef logic [`RAD_W-1:0] rad_t;

    typedef logic [`ROOT_W-1:0] root_t;

    // One operand slot in the root pipeline
    typedef struct packed {
        logic  valid;
        logic  special;
        half_t special_val;
        exp_t  res_exp;
        // Radicand bits still to be brought down, MSB first
        rad_t  rad;
        rad_t  rem;
        root_t root;
    } sqrt_work_t;

endpackage

`default_nettype wire

// ==== hdl/fp_sqrt_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_sqrt_consts.svh"

module fp_sqrt_unpack import fp_sqrt_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       valid_data_in,
    input  half_t      input_val,
    output sqrt_work_t work
);

    logic                 sign;
    exp_t                 exp_in;
    logic [`FP_MAN_W-1:0] man_in;
    logic                 special;
    half_t                special_val;
    logic [3:0]           lz;
    logic [`FP_MAN_W:0]   sig;
    logic signed [6:0]    e_unb;
    logic signed [6:0]    e_even;
    logic [`FP_MAN_W+1:0] sig_adj;
    sqrt_work_t           work_n;
    sqrt_work_t           work_q;
    logic                 valid_q;

    assign sign   = input_val[`FP_EXP_W+`FP_MAN_W];
    assign exp_in = input_val[`FP_MAN_W +: `FP_EXP_W];
    assign man_in = input_val[`FP_MAN_W-1:0];

    always_comb begin
        special     = 1'b1;
        special_val = 16'h7E00;
        priority casez ({sign, exp_in, man_in})
            16'b0_11111_0000000000: special_val = 16'h7C00;
            16'b?_11111_??????????: special_val = 16'h7E00;
            16'b?_00000_0000000000: special_val = {sign, 15'b0};
            // Negative nonzero has no real root
            16'b1_?????_??????????: special_val = 16'h7E00;
            default:                special     = 1'b0;
        endcase
    end

    // Leading zeros of the mantissa, highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < `FP_MAN_W; i++) begin
            if (man_in[i]) begin
                lz = 4'(`FP_MAN_W - 1 - i);
            end
        end
    end

    always_comb begin
        if (exp_in == '0) begin
            sig   = {1'b0, man_in} << (lz + 4'd1);
            // -14 minus a shift of lz+1
            e_unb = -7'sd15 - $signed({3'b000, lz});
        end else begin
            sig   = {1'b1, man_in};
            e_unb = $signed({2'b00, exp_in}) - 7'sd`FP_BIAS;
        end

        // Even exponent so it halves cleanly
        if (e_unb[0]) begin
            sig_adj = {sig, 1'b0};
            e_even  = e_unb - 7'sd1;
        end else begin
            sig_adj = {1'b0, sig};
            e_even  = e_unb;
        end
    end

    always_comb begin
        work_n             = '0;
        work_n.valid       = valid_data_in;
        work_n.special     = special;
        work_n.special_val = special_val;
        work_n.res_exp     = exp_t'((e_even >>> 1) + 7'sd`FP_BIAS);
        work_n.rad         = {sig_adj, {`FP_MAN_W{1'b0}}};
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_data_in;
        end
    end

    always_ff @(posedge CLK) begin
        work_q <= work_n;
    end

    always_comb begin
        work       = work_q;
        work.valid = valid_q;
    end

    // First root stage needs a leading one in the top pair
    a_rad_top: assert property (@(posedge CLK) disable iff (!nRST)
        work.valid && !work.special |-> work.rad[`RAD_W-1 -: 2] != 2'b00);

endmodule

`default_nettype wire

// ==== hdl/isqrt_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_sqrt_consts.svh"

module isqrt_stage import fp_sqrt_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  sqrt_work_t work_in,
    output sqrt_work_t work_out
);

    rad_t       rem_sh;
    rad_t       trial;
    rad_t       diff;
    logic       fits;
    sqrt_work_t work_n;
    sqrt_work_t work_q;
    logic       valid_q;

    always_comb begin
        // Bring down the next two radicand bits
        rem_sh = {work_in.rem[`RAD_W-3:0], work_in.rad[`RAD_W-1 -: 2]};
        trial  = rad_t'({work_in.root, 2'b01});
        fits   = rem_sh >= trial;
        diff   = rem_sh - trial;

        work_n      = work_in;
        work_n.rad  = {work_in.rad[`RAD_W-3:0], 2'b00};
        work_n.rem  = fits ? diff : rem_sh;
        work_n.root = {work_in.root[`ROOT_W-2:0], fits};
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= work_in.valid;
        end
    end

    always_ff @(posedge CLK) begin
        work_q <= work_n;
    end

    always_comb begin
        work_out       = work_q;
        work_out.valid = valid_q;
    end

    // Restoring invariant, otherwise the next root bit would be lost
    a_rem_bound: assert property (@(posedge CLK) disable iff (!nRST)
        work_out.valid |-> work_out.rem <= rad_t'({work_out.root, 1'b0}));

endmodule

`default_nettype wire

// ==== hdl/fp_sqrt_pack.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_sqrt_consts.svh"

module fp_sqrt_pack import fp_sqrt_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  sqrt_work_t work,
    output half_t      output_val,
    output logic       valid_data_out
);

    half_t result_n;

    // Root is 1.f with the leading one dropped
    always_comb begin
        if (work.special) begin
            result_n = work.special_val;
        end else begin
            result_n = {1'b0, work.res_exp, work.root[`FP_MAN_W-1:0]};
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_data_out <= 1'b0;
        end else begin
            valid_data_out <= work.valid;
        end
    end

    always_ff @(posedge CLK) begin
        output_val <= result_n;
    end

    // Unpack exponent range and eleven stages must give a normal result
    a_normal_out: assert property (@(posedge CLK) disable iff (!nRST)
        work.valid && !work.special |->
            work.root[`ROOT_W-1] && work.res_exp != '0 && work.res_exp != '1);

endmodule

`default_nettype wire

// ==== hdl/fp_sqrt.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_sqrt_consts.svh"

module fp_sqrt import fp_sqrt_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  valid_data_in,
    input  half_t input_val,
    output half_t output_val,
    output logic  valid_data_out
);

    // Slot k feeds root stage k, last slot feeds pack
    sqrt_work_t stage_work [0:`ROOT_W];

    fp_sqrt_unpack u_unpack (
        .CLK           (CLK),
        .nRST          (nRST),
        .valid_data_in (valid_data_in),
        .input_val     (input_val),
        .work          (stage_work[0])
    );

    genvar k;
    generate
        for (k = 0; k < `ROOT_W; k++) begin : root_stage
            isqrt_stage u_stage (
                .CLK      (CLK),
                .nRST     (nRST),
                .work_in  (stage_work[k]),
                .work_out (stage_work[k+1])
            );
        end
    endgenerate

    fp_sqrt_pack u_pack (
        .CLK            (CLK),
        .nRST           (nRST),
        .work           (stage_work[`ROOT_W]),
        .output_val     (output_val),
        .valid_data_out (valid_data_out)
    );

endmodule

`default_nettype wire

// ==== sim/fp_sqrt_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_sqrt_consts.svh"

module fp_sqrt_tb import fp_sqrt_pkg::*; ();

    localparam int RESET_CYCLES = 2;
    localparam int LEAD_IDLE    = 4;
    localparam int N_SPECIAL    = 13;
    localparam int N_SQUARE     = 10;
    localparam int N_RANDOM     = 300;
    localparam int N_SUBNORMAL  = 100;
    localparam int N_GAP        = 60;
    localparam int MAX_GAP      = 3;
    localparam int DRAIN_CYCLES = `SQRT_LATENCY + 2;
    // Every operand slot, worst-case gaps, drain and a margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + LEAD_IDLE + N_SPECIAL + N_SQUARE
        + N_RANDOM + N_SUBNORMAL + N_GAP * (1 + MAX_GAP) + DRAIN_CYCLES
        + `SQRT_LATENCY + 50;

    logic  CLK;
    logic  nRST;
    logic  valid_data_in;
    half_t input_val;
    half_t output_val;
    logic  valid_data_out;

    int          cycle_count = 0;
    logic [31:0] rng_state;
    half_t       exp_q[$];
    string       name_q[$];
    int          stamp_q[$];

    fp_sqrt DUT (
        .CLK            (CLK),
        .nRST           (nRST),
        .valid_data_in  (valid_data_in),
        .input_val      (input_val),
        .output_val     (output_val),
        .valid_data_out (valid_data_out)
    );

    always #50 CLK = ~CLK;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Truncated square root straight from the number format
    function automatic half_t ref_sqrt(input half_t x);
        logic                 sign;
        exp_t                 ex;
        logic [`FP_MAN_W-1:0] man;
        int                   e;
        int                   sig;
        int                   rad;
        int                   root;
        int                   step;
        half_t                res;
        sign = x[`FP_EXP_W+`FP_MAN_W];
        ex   = x[`FP_MAN_W +: `FP_EXP_W];
        man  = x[`FP_MAN_W-1:0];
        if (ex == '1 && man != '0) begin
            res = 16'h7E00;
        end else if (ex == '0 && man == '0) begin
            res = {sign, 15'b0};
        end else if (sign) begin
            res = 16'h7E00;
        end else if (ex == '1) begin
            res = 16'h7C00;
        end else begin
            if (ex == '0) begin
                sig = int'(man);
                e   = 1 - `FP_BIAS;
                while (sig < (1 << `FP_MAN_W)) begin
                    sig = sig * 2;
                    e   = e - 1;
                end
            end else begin
                sig = (1 << `FP_MAN_W) + int'(man);
                e   = int'(ex) - `FP_BIAS;
            end
            if (e % 2 != 0) begin
                sig = sig * 2;
                e   = e - 1;
            end
            rad  = sig * (1 << `FP_MAN_W);
            root = 0;
            for (step = 1 << `ROOT_W; step > 0; step = step / 2) begin
                if ((root + step) * (root + step) <= rad) begin
                    root = root + step;
                end
            end
            res = {1'b0, exp_t'(e / 2 + `FP_BIAS), root[`FP_MAN_W-1:0]};
        end
        return res;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
        end
    endtask

    // Launch edge index is one past the count seen before the update
    task automatic send_operand(input half_t op, input half_t expected, input string test);
        @(posedge CLK);
        valid_data_in <= 1'b1;
        input_val     <= op;
        exp_q.push_back(expected);
        name_q.push_back($sformatf("%s %04h", test, op));
        stamp_q.push_back(cycle_count + 1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLK);
            valid_data_in <= 1'b0;
        end
    endtask

    task automatic run_specials();
        send_operand(16'h0000, 16'h0000, "special");
        send_operand(16'h8000, 16'h8000, "special");
        send_operand(16'h7C00, 16'h7C00, "special");
        send_operand(16'hFC00, 16'h7E00, "special");
        send_operand(16'h7E00, 16'h7E00, "special");
        send_operand(16'h7D00, 16'h7E00, "special");
        send_operand(16'hFE00, 16'h7E00, "special");
        send_operand(16'hBC00, 16'h7E00, "special");
        send_operand(16'hC400, 16'h7E00, "special");
        send_operand(16'hFBFF, 16'h7E00, "special");
        send_operand(16'h8001, 16'h7E00, "special");
        send_operand(16'h83FF, 16'h7E00, "special");
        send_operand(16'h8200, 16'h7E00, "special");
    endtask

    // Even and odd exponents, normal and subnormal
    task automatic run_squares();
        send_operand(16'h3C00, 16'h3C00, "square");
        send_operand(16'h4400, 16'h4000, "square");
        send_operand(16'h3400, 16'h3800, "square");
        send_operand(16'h0400, 16'h2000, "square");
        send_operand(16'h7400, 16'h5800, "square");
        send_operand(16'h5C00, 16'h4C00, "square");
        send_operand(16'h4880, 16'h4200, "square");
        send_operand(16'h4080, 16'h3E00, "square");
        send_operand(16'h3880, 16'h3A00, "square");
        send_operand(16'h0001, 16'h0C00, "square");
    endtask

    task automatic run_random_normals();
        exp_t  ex;
        half_t op;
        repeat (N_RANDOM) begin
            rng_state = xorshift(rng_state);
            ex        = exp_t'(rng_state[31:16] % 30 + 1);
            op        = {1'b0, ex, rng_state[`FP_MAN_W-1:0]};
            send_operand(op, ref_sqrt(op), "random normal");
        end
    endtask

    task automatic run_subnormals();
        logic [`FP_MAN_W-1:0] man;
        half_t                op;
        send_operand(16'h0001, ref_sqrt(16'h0001), "subnormal");
        send_operand(16'h03FF, ref_sqrt(16'h03FF), "subnormal");
        repeat (N_SUBNORMAL - 2) begin
            rng_state = xorshift(rng_state);
            man       = rng_state[`FP_MAN_W-1:0];
            if (man == '0) begin
                man = 10'h155;
            end
            op = {6'b0, man};
            send_operand(op, ref_sqrt(op), "subnormal");
        end
    endtask

    // Any bit pattern, one to three idle cycles after each
    task automatic run_gapped_stream();
        half_t op;
        repeat (N_GAP) begin
            rng_state = xorshift(rng_state);
            op        = rng_state[15:0];
            send_operand(op, ref_sqrt(op), "gapped");
            rng_state = xorshift(rng_state);
            idle_cycles(int'(rng_state % MAX_GAP) + 1);
        end
    endtask

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles", cycle_count));
        end
    end

    always @(posedge CLK) begin
        half_t expected;
        string name;
        int    stamp;
        if (valid_data_out === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_run("Output strobe with no operand in flight");
            end else begin
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                stamp    = stamp_q.pop_front();
                check_equal(name, 32'(expected), 32'(output_val));
                check_equal({name, " latency"}, `SQRT_LATENCY, 32'(cycle_count - stamp));
            end
        end else if (valid_data_out !== 1'b0) begin
            fail_run("valid_data_out is unknown");
        end
    end

    initial begin
        CLK           = 1'b0;
        nRST          = 1'b1;
        valid_data_in = 1'b0;
        input_val     = '0;
        rng_state     = 32'd40854;
        // Falling reset edge after time zero
        #10;
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        idle_cycles(LEAD_IDLE);
        run_specials();
        run_squares();
        run_random_normals();
        run_subnormals();
        run_gapped_stream();
        idle_cycles(DRAIN_CYCLES);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d results never came out", exp_q.size()));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/fp_sqrt_pkg.sv
hdl/fp_sqrt_unpack.sv
hdl/isqrt_stage.sv
hdl/fp_sqrt_pack.sv
hdl/fp_sqrt.sv
sim/fp_sqrt_tb.sv

// ==== Makefile ====
# Verilator build and run for the half-float square-root unit

VERILATOR ?= verilator
TOP       ?= fp_sqrt_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hdl/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
